// File: Makefile
SIM        ?= verilator
TOP        ?= tb_alu_ft
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: alu_core.sv
// one combinational scalar ALU replica
// arithmetic, logic, shifts and comparisons on XLEN operands
module alu_core (
	input  ft_alu_pkg::alu_op_e              op_i,
	input  logic [ft_alu_pkg::XLEN-1:0]      a_i,
	input  logic [ft_alu_pkg::XLEN-1:0]      b_i,
	output ft_alu_pkg::lane_word_t           lane_o
);

	import ft_alu_pkg::*;

	logic [4:0]      shamt;
	logic [XLEN-1:0] result;
	logic            cmp;

	// shifts use only the low five bits of b
	assign shamt = b_i[4:0];

	always_comb begin
		result = '0;
		cmp    = 1'b0;
		case (op_i)
			ADD: result = a_i + b_i;
			SUB: result = a_i - b_i;
			AND: result = a_i & b_i;
			OR:  result = a_i | b_i;
			XOR: result = a_i ^ b_i;
			SLL: result = a_i << shamt;
			SRL: result = a_i >> shamt;
			// arithmetic shift keeps the sign bit
			SRA: result = $unsigned($signed(a_i) >>> shamt);
			////////////////////
			// comparisons
			////////////////////
			// result is the comparison bit zero-extended
			SLT: begin
				cmp    = ($signed(a_i) < $signed(b_i));
				result = {{(XLEN-1){1'b0}}, cmp};
			end
			SLTU: begin
				cmp    = (a_i < b_i);
				result = {{(XLEN-1){1'b0}}, cmp};
			end
			EQ: begin
				cmp    = (a_i == b_i);
				result = {{(XLEN-1){1'b0}}, cmp};
			end
			NE: begin
				cmp    = (a_i != b_i);
				result = {{(XLEN-1){1'b0}}, cmp};
			end
			// unused codes give zero
			default: begin
				result = '0;
				cmp    = 1'b0;
			end
		endcase
	end

	assign lane_o.cmp    = cmp;
	assign lane_o.result = result;

endmodule

// File: alu_ft_top.sv
// top level of the fault-tolerant ALU stage
// request FIFO, execute stage and response FIFO on plain ports
module alu_ft_top (
	input  logic                                        clk_i,
	input  logic                                        rst_n_i,
	// request stream
	input  logic                                        req_valid_i,
	output logic                                        req_ready_o,
	input  ft_alu_pkg::alu_op_e                         req_op_i,
	input  logic [ft_alu_pkg::XLEN-1:0]                 req_a_i,
	input  logic [ft_alu_pkg::XLEN-1:0]                 req_b_i,
	input  logic [ft_alu_pkg::NUM_ALU-1:0]              req_fault_mask_i,
	// response stream
	output logic                                        rsp_valid_o,
	input  logic                                        rsp_ready_i,
	output logic [ft_alu_pkg::XLEN-1:0]                 rsp_result_o,
	output logic                                        rsp_cmp_o,
	output logic                                        rsp_err_detected_o,
	output logic                                        rsp_err_corrected_o,
	// configuration and status
	input  logic [$clog2(ft_alu_pkg::NUM_ALU)-1:0]      spare_sel_i,
	output logic [ft_alu_pkg::NUM_ALU-1:0]              faulty_alu_o
);

	import ft_alu_pkg::*;

	alu_req_t req_in;
	alu_req_t req_q;
	logic     req_q_valid;
	logic     req_q_ready;

	alu_rsp_t rsp_d;
	alu_rsp_t rsp_out;
	logic     rsp_d_valid;
	logic     rsp_d_ready;

	// pack the request ports
	assign req_in.op         = req_op_i;
	assign req_in.a          = req_a_i;
	assign req_in.b          = req_b_i;
	assign req_in.fault_mask = req_fault_mask_i;

	stream_fifo #(.payload_t(alu_req_t), .DEPTH(2)) req_fifo (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (req_valid_i),
		.in_ready_o  (req_ready_o),
		.in_data_i   (req_in),
		.out_valid_o (req_q_valid),
		.out_ready_i (req_q_ready),
		.out_data_o  (req_q)
	);

	ft_execute ft_execute_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.spare_sel_i  (spare_sel_i),
		.in_valid_i   (req_q_valid),
		.in_ready_o   (req_q_ready),
		.in_req_i     (req_q),
		.out_valid_o  (rsp_d_valid),
		.out_ready_i  (rsp_d_ready),
		.out_rsp_o    (rsp_d),
		.faulty_alu_o (faulty_alu_o)
	);

	stream_fifo #(.payload_t(alu_rsp_t), .DEPTH(2)) rsp_fifo (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (rsp_d_valid),
		.in_ready_o  (rsp_d_ready),
		.in_data_i   (rsp_d),
		.out_valid_o (rsp_valid_o),
		.out_ready_i (rsp_ready_i),
		.out_data_o  (rsp_out)
	);

	// unpack the response
	assign rsp_result_o        = rsp_out.result;
	assign rsp_cmp_o           = rsp_out.cmp;
	assign rsp_err_detected_o  = rsp_out.err_detected;
	assign rsp_err_corrected_o = rsp_out.err_corrected;

endmodule

// File: fault_monitor.sv
// per-ALU saturating disagreement counters
// lane-to-ALU mapping around the standby replica
// sticky permanent-fault flags
module fault_monitor (
	input  logic                                        clk_i,
	input  logic                                        rst_n_i,
	input  logic                                        fire_i,
	input  logic [$clog2(ft_alu_pkg::NUM_ALU)-1:0]      spare_sel_i,
	input  logic [ft_alu_pkg::NUM_LANE-1:0]             lane_err_i,
	output logic [ft_alu_pkg::NUM_ALU-1:0]              faulty_alu_o
);

	import ft_alu_pkg::*;

	// error seen by each physical ALU on this request
	logic [NUM_ALU-1:0] alu_err;

	logic [CNT_W-1:0]   cnt_q [NUM_ALU];
	logic [NUM_ALU-1:0] faulty_q;

	////////////////////
	// lane to ALU mapping
	////////////////////

	// lane k sits on ALU k below the spare and on ALU k+1 from it on
	// the standby index is never written, so its counter never moves
	always_comb begin
		alu_err = '0;
		for (int k = 0; k < NUM_LANE; k++) begin
			if (k < int'(spare_sel_i)) begin
				alu_err[k] = lane_err_i[k];
			end else begin
				alu_err[k+1] = lane_err_i[k];
			end
		end
	end

	////////////////////
	// counters
	////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_ALU; i++) begin
				cnt_q[i] <= '0;
			end
			faulty_q <= '0;
		end else if (fire_i) begin
			for (int i = 0; i < NUM_ALU; i++) begin
				// count up to the threshold and stay there
				if (alu_err[i] && cnt_q[i] != CNT_W'(FAULT_THRESHOLD)) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
				// flag on the edge where the threshold is reached
				if (alu_err[i] && cnt_q[i] == CNT_W'(FAULT_THRESHOLD - 1)) begin
					faulty_q[i] <= 1'b1;
				end
			end
		end
	end

	// flags are only cleared by reset
	assign faulty_alu_o = faulty_q;

endmodule

// File: ft_alu_pkg.sv
// shared definitions of the fault-tolerant ALU stage
// widths, replica counts and the permanent-fault threshold
// operation codes and the request, lane and response structs
package ft_alu_pkg;

	////////////////////
	// sizes
	////////////////////

	// operand and result width
	localparam int unsigned XLEN = 32;
	// physical replicas, one of them is the standby
	localparam int unsigned NUM_ALU = 4;
	// lanes that go into the majority vote
	localparam int unsigned NUM_LANE = 3;
	// disagreements after which a replica is marked permanently faulty
	localparam int unsigned FAULT_THRESHOLD = 4;
	// counter width, must hold FAULT_THRESHOLD itself
	localparam int unsigned CNT_W = $clog2(FAULT_THRESHOLD + 1);
	// operation code width
	localparam int unsigned ALU_OP_W = 4;

	////////////////////
	// types
	////////////////////

	// scalar operations, codes 12..15 are unused
	typedef enum logic [ALU_OP_W-1:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, EQ, NE
	} alu_op_e;

	// one request, fault_mask has one bit per physical replica
	typedef struct packed {
		alu_op_e             op;
		logic [XLEN-1:0]     a;
		logic [XLEN-1:0]     b;
		logic [NUM_ALU-1:0]  fault_mask;
	} alu_req_t;

	// output word of a single replica, the unit of voting
	typedef struct packed {
		logic             cmp;
		logic [XLEN-1:0]  result;
	} lane_word_t;

	// one voted response with the voter status
	typedef struct packed {
		logic [XLEN-1:0]  result;
		logic             cmp;
		logic             err_detected;
		logic             err_corrected;
	} alu_rsp_t;

endpackage

// File: ft_execute.sv
// fault-tolerant execute stage
// four ALU replicas with per-replica fault injection
// spare-aware lane selection, majority voter and fault monitor
module ft_execute (
	input  logic                                        clk_i,
	input  logic                                        rst_n_i,
	input  logic [$clog2(ft_alu_pkg::NUM_ALU)-1:0]      spare_sel_i,
	// request side
	input  logic                                        in_valid_i,
	output logic                                        in_ready_o,
	input  ft_alu_pkg::alu_req_t                        in_req_i,
	// response side
	output logic                                        out_valid_o,
	input  logic                                        out_ready_i,
	output ft_alu_pkg::alu_rsp_t                        out_rsp_o,
	// sticky per-ALU fault flags
	output logic [ft_alu_pkg::NUM_ALU-1:0]              faulty_alu_o
);

	import ft_alu_pkg::*;

	lane_word_t alu_word [NUM_ALU];
	lane_word_t inj_word [NUM_ALU];
	lane_word_t lane_word [NUM_LANE];
	lane_word_t voted;

	logic [NUM_LANE-1:0] lane_err;
	logic                err_detected;
	logic                err_corrected;
	logic                fire;

	// the stage is combinational, one request in gives one response out
	assign fire        = in_valid_i && out_ready_i;
	assign in_ready_o  = out_ready_i;
	assign out_valid_o = in_valid_i;

	////////////////////
	// replicas
	////////////////////

	for (genvar i = 0; i < NUM_ALU; i++) begin : g_alu
		alu_core alu_core_i (
			.op_i   (in_req_i.op),
			.a_i    (in_req_i.a),
			.b_i    (in_req_i.b),
			.lane_o (alu_word[i])
		);

		// injected fault flips result bit 0 of this replica only
		assign inj_word[i].cmp    = alu_word[i].cmp;
		assign inj_word[i].result = alu_word[i].result ^ XLEN'(in_req_i.fault_mask[i]);
	end

	////////////////////
	// lane selection
	////////////////////

	// three of four replicas go to the voter, the spare is skipped
	for (genvar k = 0; k < NUM_LANE; k++) begin : g_lane
		assign lane_word[k] = (k < int'(spare_sel_i)) ? inj_word[k] : inj_word[k+1];
	end

	tmr_voter tmr_voter_i (
		.lane0_i         (lane_word[0]),
		.lane1_i         (lane_word[1]),
		.lane2_i         (lane_word[2]),
		.voted_o         (voted),
		.lane_err_o      (lane_err),
		.err_detected_o  (err_detected),
		.err_corrected_o (err_corrected)
	);

	// counts only on a real transfer, a stalled request is not counted twice
	fault_monitor fault_monitor_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.fire_i       (fire),
		.spare_sel_i  (spare_sel_i),
		.lane_err_i   (lane_err),
		.faulty_alu_o (faulty_alu_o)
	);

	// response assembly
	assign out_rsp_o.result        = voted.result;
	assign out_rsp_o.cmp           = voted.cmp;
	assign out_rsp_o.err_detected  = err_detected;
	assign out_rsp_o.err_corrected = err_corrected;

endmodule

// File: stream_fifo.sv
// valid/ready FIFO with registered storage and no fall-through
// payload type and depth are parameters, depth a power of two of at least 2
module stream_fifo #(
	parameter type         payload_t = logic,
	parameter int unsigned DEPTH     = 2
) (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// producer side
	input  logic      in_valid_i,
	output logic      in_ready_o,
	input  payload_t  in_data_i,
	// consumer side
	output logic      out_valid_o,
	input  logic      out_ready_i,
	output payload_t  out_data_o
);

	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	// storage, no reset needed since count guards every read
	payload_t mem_q [DEPTH];

	ptr_t wr_ptr_q;
	ptr_t rd_ptr_q;
	cnt_t count_q;

	logic push;
	logic pop;
	logic full;

	assign full = (count_q == cnt_t'(DEPTH));

	// a full FIFO still takes an item when the head leaves in the same cycle
	assign in_ready_o  = !full || out_ready_i;
	assign out_valid_o = (count_q != '0);
	assign out_data_o  = mem_q[rd_ptr_q];

	assign push = in_valid_i && in_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	////////////////////
	// pointers and count
	////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// pointers wrap naturally, depth is a power of two
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// push and pop together leave the count unchanged
			if (push && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// payload write
	always_ff @(posedge clk_i) begin
		if (push) begin
			mem_q[wr_ptr_q] <= in_data_i;
		end
	end

endmodule

// File: tb_alu_ft.sv
// directed testbench for the fault-tolerant ALU stage
// reference model, xorshift operands, single check task
// tests for clean ops, injected faults, reconfiguration and back-pressure
module tb_alu_ft;

	import ft_alu_pkg::*;

	localparam logic [31:0] SEED    = 32'd84;
	localparam int          TIMEOUT = 64;

	logic                        clk_i;
	logic                        rst_n_i;
	logic                        req_valid_i;
	logic                        req_ready_o;
	alu_op_e                     req_op_i;
	logic [XLEN-1:0]             req_a_i;
	logic [XLEN-1:0]             req_b_i;
	logic [NUM_ALU-1:0]          req_fault_mask_i;
	logic                        rsp_valid_o;
	logic                        rsp_ready_i;
	logic [XLEN-1:0]             rsp_result_o;
	logic                        rsp_cmp_o;
	logic                        rsp_err_detected_o;
	logic                        rsp_err_corrected_o;
	logic [$clog2(NUM_ALU)-1:0]  spare_sel_i;
	logic [NUM_ALU-1:0]          faulty_alu_o;

	logic [31:0] rng_state;
	string       test_name;

	alu_ft_top dut0 (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string field, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Mismatch %s %s: expected 0x%08h actual 0x%08h",
				test_name, field, expected, actual));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic draw_random(output logic [XLEN-1:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// reference ALU where comparisons give cmp zero-extended as result
	function automatic lane_word_t model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		lane_word_t        w;
		logic [2*XLEN-1:0] ext;
		logic [4:0]        sh;
		sh       = b[4:0];
		w.cmp    = 1'b0;
		w.result = '0;
		case (op)
			ADD: w.result = a + b;
			SUB: w.result = a + ~b + 1'b1;
			AND: w.result = a & b;
			OR:  w.result = a | b;
			XOR: w.result = a ^ b;
			SLL: w.result = a << sh;
			SRL: w.result = a >> sh;
			// sign-fill the upper half, shift, keep the low word
			SRA: begin
				ext      = {{XLEN{a[XLEN-1]}}, a} >> sh;
				w.result = ext[XLEN-1:0];
			end
			// differing signs decide at once
			SLT:  w.cmp = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
			SLTU: w.cmp = (a < b);
			EQ:   w.cmp = (a == b);
			NE:   w.cmp = (a != b);
			default: w.result = '0;
		endcase
		if (op inside {SLT, SLTU, EQ, NE}) begin
			w.result = {{(XLEN-1){1'b0}}, w.cmp};
		end
		return w;
	endfunction

	task automatic wait_req_ready();
		int waited;
		waited = 0;
		while (!req_ready_o) begin
			if (waited == TIMEOUT) begin
				abort_run($sformatf("timeout in %s, request was never accepted", test_name));
			end
			@(negedge clk_i);
			waited++;
		end
	endtask

	task automatic wait_rsp_valid();
		int waited;
		waited = 0;
		while (!rsp_valid_o) begin
			if (waited == TIMEOUT) begin
				abort_run($sformatf("timeout in %s, no response arrived", test_name));
			end
			@(negedge clk_i);
			waited++;
		end
	endtask

	// flip marks a double fault where the vote takes the wrong bit 0
	task automatic compare_response(input lane_word_t exp_w, input logic flip,
			input logic exp_err);
		check_value("result", exp_w.result ^ XLEN'(flip), rsp_result_o);
		check_value("cmp", XLEN'(exp_w.cmp), XLEN'(rsp_cmp_o));
		check_value("err_detected", XLEN'(exp_err), XLEN'(rsp_err_detected_o));
		check_value("err_corrected", XLEN'(exp_err), XLEN'(rsp_err_corrected_o));
	endtask

	// one request in and one response out while rsp_ready_i stays high
	task automatic send_and_check(input alu_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [NUM_ALU-1:0] mask,
			input logic flip, input logic exp_err);
		@(negedge clk_i);
		req_valid_i      = 1'b1;
		req_op_i         = op;
		req_a_i          = a;
		req_b_i          = b;
		req_fault_mask_i = mask;
		wait_req_ready();
		// taken on the rising edge before this falling edge
		@(negedge clk_i);
		req_valid_i = 1'b0;
		wait_rsp_valid();
		compare_response(model_alu(op, a, b), flip, exp_err);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic clean_operations();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		test_name = "clean_operations";
		for (int i = 0; i < 12; i++) begin
			for (int j = 0; j < 12; j++) begin
				draw_random(a);
				draw_random(b);
				// equal operands once per op so EQ and NE see both outcomes
				if (j == 0) begin
					b = a;
				end
				send_and_check(alu_op_e'(i), a, b, '0, 1'b0, 1'b0);
			end
		end
	endtask

	// with ALU 3 as the spare ALU 0 sits on lane 0
	task automatic single_fault_voted();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		test_name = "single_fault_voted";
		draw_random(a);
		draw_random(b);
		send_and_check(ADD, a, b, 4'b0001, 1'b0, 1'b1);
		send_and_check(SLTU, a, b, 4'b0001, 1'b0, 1'b1);
	endtask

	// enough standby faults to reach the threshold if the standby were counted
	task automatic standby_fault();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		test_name = "standby_fault";
		for (int i = 0; i < int'(FAULT_THRESHOLD); i++) begin
			draw_random(a);
			draw_random(b);
			send_and_check(alu_op_e'(i + 4), a, b, 4'b1000, 1'b0, 1'b0);
		end
		check_value("faulty_alu", '0, XLEN'(faulty_alu_o));
	endtask

	// two bad lanes outvote the good one on bit 0
	task automatic double_fault_voted();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		test_name = "double_fault_voted";
		draw_random(a);
		draw_random(b);
		send_and_check(XOR, a, b, 4'b0011, 1'b1, 1'b1);
	endtask

	task automatic permanent_fault_reconfig();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		test_name = "permanent_fault_reconfig";
		for (int i = 0; i < int'(FAULT_THRESHOLD); i++) begin
			check_value("faulty_alu before threshold", '0, XLEN'(faulty_alu_o));
			draw_random(a);
			draw_random(b);
			send_and_check(alu_op_e'(i), a, b, 4'b0010, 1'b0, 1'b1);
		end
		check_value("faulty_alu at threshold", XLEN'(4'b0010), XLEN'(faulty_alu_o));
		// ALU 1 becomes the standby while nothing is in flight
		@(negedge clk_i);
		spare_sel_i = 2'd1;
		for (int i = 0; i < 4; i++) begin
			draw_random(a);
			draw_random(b);
			send_and_check(alu_op_e'(i + 8), a, b, 4'b0010, 1'b0, 1'b0);
		end
		check_value("faulty_alu after reconfig", XLEN'(4'b0010), XLEN'(faulty_alu_o));
	endtask

	task automatic backpressure_order();
		lane_word_t      exp_q[$];
		lane_word_t      exp_w;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		int              accepted;
		test_name = "backpressure_order";
		accepted  = 0;
		@(negedge clk_i);
		rsp_ready_i = 1'b0;
		@(negedge clk_i);
		// offer new requests until both FIFOs are full
		while (req_ready_o) begin
			if (accepted == 4) begin
				abort_run("more than four requests accepted while responses were stalled");
			end
			draw_random(a);
			draw_random(b);
			req_valid_i      = 1'b1;
			req_op_i         = alu_op_e'(accepted * 3);
			req_a_i          = a;
			req_b_i          = b;
			req_fault_mask_i = '0;
			exp_q.push_back(model_alu(req_op_i, a, b));
			accepted++;
			@(negedge clk_i);
		end
		req_valid_i = 1'b0;
		repeat (3) @(negedge clk_i);
		check_value("rsp_valid while stalled", XLEN'(1'b1), XLEN'(rsp_valid_o));
		rsp_ready_i = 1'b1;
		// responses must drain in request order
		while (exp_q.size() > 0) begin
			wait_rsp_valid();
			exp_w = exp_q.pop_front();
			compare_response(exp_w, 1'b0, 1'b0);
			@(negedge clk_i);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		rst_n_i          = 1'b0;
		req_valid_i      = 1'b0;
		req_op_i         = ADD;
		req_a_i          = '0;
		req_b_i          = '0;
		req_fault_mask_i = '0;
		rsp_ready_i      = 1'b1;
		spare_sel_i      = 2'd3;
		rng_state        = SEED;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		test_name = "reset";
		check_value("req_ready", XLEN'(1'b1), XLEN'(req_ready_o));
		check_value("rsp_valid", '0, XLEN'(rsp_valid_o));
		check_value("faulty_alu", '0, XLEN'(faulty_alu_o));
		clean_operations();
		single_fault_voted();
		standby_fault();
		double_fault_voted();
		permanent_fault_reconfig();
		backpressure_order();
		$display("sim passed");
		$finish;
	end

endmodule

// File: tmr_voter.sv
// bitwise two-of-three majority voter over lane words
// per-lane disagreement flags, detected and corrected status
module tmr_voter (
	input  ft_alu_pkg::lane_word_t              lane0_i,
	input  ft_alu_pkg::lane_word_t              lane1_i,
	input  ft_alu_pkg::lane_word_t              lane2_i,
	output ft_alu_pkg::lane_word_t              voted_o,
	output logic [ft_alu_pkg::NUM_LANE-1:0]     lane_err_o,
	output logic                                err_detected_o,
	output logic                                err_corrected_o
);

	import ft_alu_pkg::*;

	lane_word_t voted;

	// each bit takes the value held by at least two lanes
	// cmp and result are voted together as one word
	assign voted = (lane0_i & lane1_i) | (lane0_i & lane2_i) | (lane1_i & lane2_i);

	assign voted_o = voted;

	////////////////////
	// disagreement
	////////////////////

	// a lane is wrong when any of its bits lost the vote
	assign lane_err_o[0] = (lane0_i != voted);
	assign lane_err_o[1] = (lane1_i != voted);
	assign lane_err_o[2] = (lane2_i != voted);

	assign err_detected_o = |lane_err_o;

	// bits can be outvoted in different lanes so that no lane
	// matches the voted word; the vote is then not trustworthy
	assign err_corrected_o = err_detected_o && !(&lane_err_o);

endmodule

// File: vlog.f
ft_alu_pkg.sv
stream_fifo.sv
alu_core.sv
tmr_voter.sv
fault_monitor.sv
ft_execute.sv
alu_ft_top.sv
tb_alu_ft.sv
